//--- design/paletteTable.svh
/*
  64-entry sprite palette, included inside colorPkg after rgbT.
  Entry 0 is the transparent key; unused entries repeat it.
*/
`ifndef PALETTE_TABLE_SVH
`define PALETTE_TABLE_SVH

`default_nettype none

localparam rgbT PaletteColors [64] = '{
    // Key, whites and darks
    24'hF400FF, 24'hFFFFFE, 24'hC9C9C9, 24'h030303,
    24'h1E1E1E, 24'h474747, 24'h3F0606, 24'h880606,
    // Reds and skin
    24'hAB0000, 24'hA40000, 24'h5A2712, 24'hDF4426,
    24'hFF0000, 24'hFFC78F, 24'hEFE300, 24'h154269,
    24'h323E92, 24'hED1C24, 24'h342505, 24'h47450F,
    // Greens and browns
    24'h126401, 24'h064100, 24'h080000, 24'h1E0B05,
    24'h893A1A, 24'h873B19, 24'hB35A32, 24'hF30000,
    24'h640000, 24'hF35B5B, 24'h676868, 24'h8F8F8E,
    // Grey ramp used by the block tiles
    24'hC9C9C8, 24'h262626, 24'h454444, 24'h353434,
    24'h302F2F, 24'h3E3C3C, 24'hA4A4A4, 24'h545555,
    24'hB2B2B1, 24'hDFDFDE, 24'h666565, 24'h535252,
    24'h1E1E1E, 24'h414040, 24'hD6D5D5, 24'hBBBABA,
    24'hCAC9C9, 24'h595858, 24'h878787, 24'h5A5A5A,
    24'h2C2B2B, 24'h737373, 24'h393939, 24'h6E6E6E,
    24'hEBEBEB, 24'hFAFAFA, 24'h6E6E6E, 24'h434343,
    // Unused
    24'hF400FF, 24'hF400FF, 24'hF400FF, 24'hF400FF
};

`default_nettype wire

`endif

//--- design/colorPkg.sv
/*
  Widths, layer kinds and screen constants shared by the colour mapper.
  Coordinates are 10-bit raster positions, and probe arithmetic wraps at 1024.
*/
`default_nettype none

package colorPkg;

    typedef logic [9:0]  coordT;
    typedef logic [5:0]  paletteIndexT;
    typedef logic [23:0] rgbT;
    typedef logic [6:0]  lifeCountT;

    // Layer chosen for a pixel, in raster priority terms
    typedef enum logic [1:0] {
        LayerNone,
        LayerPlayer,
        LayerBlock,
        LayerHazard
    } layerKindT;

    // ----------------------------------------
    // Palette
    // ----------------------------------------
    localparam paletteIndexT TransparentIndex = 6'd0;

    `include "paletteTable.svh"

    localparam rgbT BulletColor = 24'hFFFFFF;

    // Sky gradient, green rises with drawY
    localparam logic [7:0] BackgroundRed       = 8'h10;
    localparam logic [7:0] BackgroundGreenBase = 8'h51;
    localparam logic [7:0] BackgroundBlue      = 8'hC9;

    // ----------------------------------------
    // Gameplay probes
    // ----------------------------------------
    localparam coordT     GroundProbeOffset = 10'd10;
    localparam coordT     SideProbeOffset   = 10'd12;
    localparam lifeCountT LifeCountMax      = 7'd99;

endpackage

`default_nettype wire

//--- design/layerSelect.sv
/*
  Pipeline stage 1. Resolves which layer wins the pixel and which one
  sits under the player. Hit flags are trusted as given by the sprite engine.
*/
`default_nettype none

module layerSelect
    import colorPkg::*;
(
    input  logic         Clk,
    input  logic         arstN,
    input  coordT        drawX,
    input  coordT        drawY,
    input  logic         playerHit,
    input  logic         blockHit,
    input  logic         hazardHit,
    input  logic         bulletHit,
    input  paletteIndexT playerIndex,
    input  paletteIndexT blockIndex,
    input  paletteIndexT hazardIndex,
    output coordT        selX,
    output coordT        selY,
    output layerKindT    foreKind,
    output layerKindT    underKind,
    output paletteIndexT selPlayerIndex,
    output paletteIndexT selBlockIndex,
    output paletteIndexT selHazardIndex,
    output logic         selPlayerHit,
    output logic         selBlockHit,
    output logic         selHazardHit,
    output logic         selBullet
);

    layerKindT foreNext;
    layerKindT underNext;

    // Player over block over hazard
    always_comb
    begin
        if (playerHit)
            foreNext = LayerPlayer;
        else if (blockHit)
            foreNext = LayerBlock;
        else if (hazardHit)
            foreNext = LayerHazard;
        else
            foreNext = LayerNone;

        // What shows through a transparent player pixel
        if (hazardHit)
            underNext = LayerHazard;
        else if (blockHit)
            underNext = LayerBlock;
        else
            underNext = LayerNone;
    end

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            selX           <= '0;
            selY           <= '0;
            foreKind       <= LayerNone;
            underKind      <= LayerNone;
            selPlayerIndex <= '0;
            selBlockIndex  <= '0;
            selHazardIndex <= '0;
            selPlayerHit   <= 1'b0;
            selBlockHit    <= 1'b0;
            selHazardHit   <= 1'b0;
            selBullet      <= 1'b0;
        end
        else
        begin
            selX           <= drawX;
            selY           <= drawY;
            foreKind       <= foreNext;
            underKind      <= underNext;
            selPlayerIndex <= playerIndex;
            selBlockIndex  <= blockIndex;
            selHazardIndex <= hazardIndex;
            selPlayerHit   <= playerHit;
            selBlockHit    <= blockHit;
            selHazardHit   <= hazardHit;
            selBullet      <= bulletHit;
        end
    end

    // Sprite engine must never feed X into the priority chain
    foreKnownAssert : assert property (
        @(posedge Clk) disable iff (!arstN) !$isunknown(foreKind)
    );

endmodule

`default_nettype wire

//--- design/paletteLookup.sv
/*
  Pipeline stage 2. Three parallel reads of the shared palette.
  A layer is opaque only when hit and not on the transparent index.
*/
`default_nettype none

module paletteLookup
    import colorPkg::*;
(
    input  logic         Clk,
    input  logic         arstN,
    input  coordT        selX,
    input  coordT        selY,
    input  layerKindT    foreKind,
    input  layerKindT    underKind,
    input  paletteIndexT selPlayerIndex,
    input  paletteIndexT selBlockIndex,
    input  paletteIndexT selHazardIndex,
    input  logic         selPlayerHit,
    input  logic         selBlockHit,
    input  logic         selHazardHit,
    input  logic         selBullet,
    output coordT        lookX,
    output coordT        lookY,
    output layerKindT    lookFore,
    output layerKindT    lookUnder,
    output rgbT          playerColor,
    output rgbT          blockColor,
    output rgbT          hazardColor,
    output logic         playerOpaque,
    output logic         blockOpaque,
    output logic         hazardOpaque,
    output logic         lookBullet
);

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            lookX        <= '0;
            lookY        <= '0;
            lookFore     <= LayerNone;
            lookUnder    <= LayerNone;
            playerColor  <= '0;
            blockColor   <= '0;
            hazardColor  <= '0;
            playerOpaque <= 1'b0;
            blockOpaque  <= 1'b0;
            hazardOpaque <= 1'b0;
            lookBullet   <= 1'b0;
        end
        else
        begin
            lookX        <= selX;
            lookY        <= selY;
            lookFore     <= foreKind;
            lookUnder    <= underKind;
            playerColor  <= PaletteColors[selPlayerIndex];
            blockColor   <= PaletteColors[selBlockIndex];
            hazardColor  <= PaletteColors[selHazardIndex];
            playerOpaque <= selPlayerHit && (selPlayerIndex != TransparentIndex);
            blockOpaque  <= selBlockHit && (selBlockIndex != TransparentIndex);
            hazardOpaque <= selHazardHit && (selHazardIndex != TransparentIndex);
            lookBullet   <= selBullet;
        end
    end

endmodule

`default_nettype wire

//--- design/pixelCompositor.sv
/*
  Pipeline stage 3. Composites layers over bullet and sky gradient,
  registers RGB and hands the opacity flags on to the probe stage.
*/
`default_nettype none

module pixelCompositor
    import colorPkg::*;
(
    input  logic       Clk,
    input  logic       arstN,
    input  coordT      lookX,
    input  coordT      lookY,
    input  layerKindT  lookFore,
    input  layerKindT  lookUnder,
    input  rgbT        playerColor,
    input  rgbT        blockColor,
    input  rgbT        hazardColor,
    input  logic       playerOpaque,
    input  logic       blockOpaque,
    input  logic       hazardOpaque,
    input  logic       lookBullet,
    output logic [7:0] vgaRed,
    output logic [7:0] vgaGreen,
    output logic [7:0] vgaBlue,
    output coordT      outX,
    output coordT      outY,
    output logic       outPlayerOpaque,
    output logic       outBlockOpaque,
    output logic       outHazardOpaque
);

    localparam rgbT KeyColor = PaletteColors[TransparentIndex];

    rgbT         underColor;
    logic        underOpaque;
    logic [12:0] gradStep;
    rgbT         pixel;

    always_comb
    begin
        case (lookUnder)
            LayerHazard:
            begin
                underColor  = hazardColor;
                underOpaque = hazardOpaque;
            end
            LayerBlock:
            begin
                underColor  = blockColor;
                underOpaque = blockOpaque;
            end
            default:
            begin
                underColor  = KeyColor;
                underOpaque = 1'b0;
            end
        endcase

        // 6 * 1023 still fits in 13 bits
        gradStep = (13'd6 * 13'(lookY)) / 13'd25;

        if (lookFore == LayerPlayer && playerOpaque)
            pixel = playerColor;
        else if (lookFore == LayerPlayer && underOpaque)
            pixel = underColor;
        else if (lookFore == LayerBlock && blockOpaque)
            pixel = blockColor;
        else if (lookFore == LayerHazard && hazardOpaque)
            pixel = hazardColor;
        else if (lookBullet)
            pixel = BulletColor;
        else
            pixel = {BackgroundRed, BackgroundGreenBase + gradStep[7:0], BackgroundBlue};
    end

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            vgaRed          <= '0;
            vgaGreen        <= '0;
            vgaBlue         <= '0;
            outX            <= '0;
            outY            <= '0;
            outPlayerOpaque <= 1'b0;
            outBlockOpaque  <= 1'b0;
            outHazardOpaque <= 1'b0;
        end
        else
        begin
            {vgaRed, vgaGreen, vgaBlue} <= pixel;
            outX            <= lookX;
            outY            <= lookY;
            outPlayerOpaque <= playerOpaque;
            outBlockOpaque  <= blockOpaque;
            outHazardOpaque <= hazardOpaque;
        end
    end

    // Transparent key must never reach the screen
    keyColorAssert : assert property (
        @(posedge Clk) disable iff (!arstN) {vgaRed, vgaGreen, vgaBlue} != KeyColor
    );

endmodule

`default_nettype wire

//--- design/probeMonitor.sv
/*
  Collision and contact flags, one cycle behind the composited pixel.
  playerX, playerY and facingRight must hold steady around a probe pixel.
*/
`default_nettype none

module probeMonitor
    import colorPkg::*;
(
    input  logic      Clk,
    input  logic      arstN,
    input  coordT     outX,
    input  coordT     outY,
    input  logic      outPlayerOpaque,
    input  logic      outBlockOpaque,
    input  logic      outHazardOpaque,
    input  coordT     playerX,
    input  coordT     playerY,
    input  logic      facingRight,
    input  logic      restart,
    input  logic      clearCount,
    output logic      dead,
    output logic      inAir,
    output logic      blocked,
    output logic      top,
    output lifeCountT lifeCount
);

    coordT footY;
    coordT headY;
    coordT sideX;
    logic  hit;
    logic  deadRise;

    assign footY = playerY + GroundProbeOffset;
    assign headY = playerY - GroundProbeOffset;
    assign sideX = facingRight ? playerX + SideProbeOffset : playerX - SideProbeOffset;

    assign hit      = outPlayerOpaque && outHazardOpaque;
    assign deadRise = hit && !dead && !restart;

    // ----------------------------------------
    // Death flag and life counter
    // ----------------------------------------
    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            dead      <= 1'b0;
            lifeCount <= '0;
        end
        else
        begin
            if (restart)
                dead <= 1'b0;
            else if (hit)
                dead <= 1'b1;

            if (clearCount)
                lifeCount <= '0;
            else if (deadRise && lifeCount < LifeCountMax)
                lifeCount <= lifeCount + 7'd1;
        end
    end

    // ----------------------------------------
    // Block contact probes
    // ----------------------------------------
    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            inAir   <= 1'b0;
            top     <= 1'b0;
            blocked <= 1'b0;
        end
        else
        begin
            if (outX == playerX && outY == footY)
                inAir <= !outBlockOpaque;
            if (outX == playerX && outY == headY)
                top <= outBlockOpaque;
            if (outX == sideX && outY == playerY)
                blocked <= outBlockOpaque;
        end
    end

    lifeLimitAssert : assert property (
        @(posedge Clk) disable iff (!arstN) lifeCount <= LifeCountMax
    );

endmodule

`default_nettype wire

//--- design/colorMapper.sv
/*
  Colour mapper top. One pixel per clock, RGB three cycles after the
  coordinate and status flags one cycle later. No back-pressure.
*/
`default_nettype none

module colorMapper
    import colorPkg::*;
(
    input  logic         Clk,
    input  logic         arstN,
    input  coordT        drawX,
    input  coordT        drawY,
    input  logic         playerHit,
    input  paletteIndexT playerIndex,
    input  logic         blockHit,
    input  paletteIndexT blockIndex,
    input  logic         hazardHit,
    input  paletteIndexT hazardIndex,
    input  logic         bulletHit,
    input  coordT        playerX,
    input  coordT        playerY,
    input  logic         facingRight,
    input  logic         restart,
    input  logic         clearCount,
    output logic [7:0]   vgaRed,
    output logic [7:0]   vgaGreen,
    output logic [7:0]   vgaBlue,
    output logic         dead,
    output logic         inAir,
    output logic         blocked,
    output logic         top,
    output lifeCountT    lifeCount
);

    // Stage 1 to 2
    coordT        selX;
    coordT        selY;
    layerKindT    foreKind;
    layerKindT    underKind;
    paletteIndexT selPlayerIndex;
    paletteIndexT selBlockIndex;
    paletteIndexT selHazardIndex;
    logic         selPlayerHit;
    logic         selBlockHit;
    logic         selHazardHit;
    logic         selBullet;

    // Stage 2 to 3
    coordT     lookX;
    coordT     lookY;
    layerKindT lookFore;
    layerKindT lookUnder;
    rgbT       playerColor;
    rgbT       blockColor;
    rgbT       hazardColor;
    logic      playerOpaque;
    logic      blockOpaque;
    logic      hazardOpaque;
    logic      lookBullet;

    // Stage 3 to probes
    coordT outX;
    coordT outY;
    logic  outPlayerOpaque;
    logic  outBlockOpaque;
    logic  outHazardOpaque;

    layerSelect uLayerSelect (
        .Clk(Clk), .arstN(arstN),
        .drawX(drawX), .drawY(drawY),
        .playerHit(playerHit), .blockHit(blockHit),
        .hazardHit(hazardHit), .bulletHit(bulletHit),
        .playerIndex(playerIndex), .blockIndex(blockIndex), .hazardIndex(hazardIndex),
        .selX(selX), .selY(selY),
        .foreKind(foreKind), .underKind(underKind),
        .selPlayerIndex(selPlayerIndex), .selBlockIndex(selBlockIndex),
        .selHazardIndex(selHazardIndex),
        .selPlayerHit(selPlayerHit), .selBlockHit(selBlockHit),
        .selHazardHit(selHazardHit), .selBullet(selBullet)
    );

    paletteLookup uPaletteLookup (
        .Clk(Clk), .arstN(arstN),
        .selX(selX), .selY(selY),
        .foreKind(foreKind), .underKind(underKind),
        .selPlayerIndex(selPlayerIndex), .selBlockIndex(selBlockIndex),
        .selHazardIndex(selHazardIndex),
        .selPlayerHit(selPlayerHit), .selBlockHit(selBlockHit),
        .selHazardHit(selHazardHit), .selBullet(selBullet),
        .lookX(lookX), .lookY(lookY),
        .lookFore(lookFore), .lookUnder(lookUnder),
        .playerColor(playerColor), .blockColor(blockColor), .hazardColor(hazardColor),
        .playerOpaque(playerOpaque), .blockOpaque(blockOpaque),
        .hazardOpaque(hazardOpaque), .lookBullet(lookBullet)
    );

    pixelCompositor uPixelCompositor (
        .Clk(Clk), .arstN(arstN),
        .lookX(lookX), .lookY(lookY),
        .lookFore(lookFore), .lookUnder(lookUnder),
        .playerColor(playerColor), .blockColor(blockColor), .hazardColor(hazardColor),
        .playerOpaque(playerOpaque), .blockOpaque(blockOpaque),
        .hazardOpaque(hazardOpaque), .lookBullet(lookBullet),
        .vgaRed(vgaRed), .vgaGreen(vgaGreen), .vgaBlue(vgaBlue),
        .outX(outX), .outY(outY),
        .outPlayerOpaque(outPlayerOpaque), .outBlockOpaque(outBlockOpaque),
        .outHazardOpaque(outHazardOpaque)
    );

    probeMonitor uProbeMonitor (
        .Clk(Clk), .arstN(arstN),
        .outX(outX), .outY(outY),
        .outPlayerOpaque(outPlayerOpaque), .outBlockOpaque(outBlockOpaque),
        .outHazardOpaque(outHazardOpaque),
        .playerX(playerX), .playerY(playerY), .facingRight(facingRight),
        .restart(restart), .clearCount(clearCount),
        .dead(dead), .inAir(inAir), .blocked(blocked), .top(top),
        .lifeCount(lifeCount)
    );

endmodule

`default_nettype wire

//--- verification/colorMapperTb.sv
/*
  Random-stimulus testbench for colorMapper with a queue-based reference model.
  One pixel per clock is assumed; every rising edge after reset carries a pixel.
  Player position and facing change only between probe pixels.
*/
`default_nettype none

module colorMapperTb
    import colorPkg::*;
();

    localparam int          ClkPeriod        = 4;
    localparam int          ResetCycles      = 16;
    localparam logic [31:0] Seed             = 32'h855b60fe;
    localparam int          LayerCycles      = 405;
    localparam int          BackgroundCycles = 305;
    localparam int          DeathCycles      = 60;
    localparam int          LifeCycles       = 750;
    localparam int          ProbeCycles      = 270;
    localparam int          PlannedCycles    = ResetCycles + LayerCycles + BackgroundCycles
                                             + DeathCycles + LifeCycles + ProbeCycles;
    localparam int          WatchdogTime     = 2 * PlannedCycles * ClkPeriod;

    typedef struct packed {
        coordT        x;
        coordT        y;
        logic         pHit;
        paletteIndexT pIdx;
        logic         bHit;
        paletteIndexT bIdx;
        logic         hHit;
        paletteIndexT hIdx;
        logic         bullet;
    } pixelT;

    typedef struct packed {
        rgbT   color;
        coordT x;
        coordT y;
        logic  pOpq;
        logic  bOpq;
        logic  hOpq;
    } expectT;

    logic         Clk;
    logic         arstN;
    coordT        drawX;
    coordT        drawY;
    logic         playerHit;
    paletteIndexT playerIndex;
    logic         blockHit;
    paletteIndexT blockIndex;
    logic         hazardHit;
    paletteIndexT hazardIndex;
    logic         bulletHit;
    coordT        playerX;
    coordT        playerY;
    logic         facingRight;
    logic         restart;
    logic         clearCount;
    logic [7:0]   vgaRed;
    logic [7:0]   vgaGreen;
    logic [7:0]   vgaBlue;
    logic         dead;
    logic         inAir;
    logic         blocked;
    logic         top;
    lifeCountT    lifeCount;

    // Control values applied at the next pixel
    coordT ctlPlayerX;
    coordT ctlPlayerY;
    logic  ctlFacing;
    logic  ctlRestart;
    logic  ctlClear;

    // Reference model state
    expectT    expectQ[$];
    expectT    popped;
    logic      modelDead;
    logic      modelInAir;
    logic      modelBlocked;
    logic      modelTop;
    lifeCountT modelLife;

    int checkCount;
    int errorCount;

    colorMapper dut (.*);

    initial
    begin
        Clk = 1'b0;
        forever #(ClkPeriod / 2) Clk = ~Clk;
    end

    initial
    begin
        #(WatchdogTime);
        $display("TIMEOUT: run did not finish within %0d time units", WatchdogTime);
        $display("FAIL: see errors above");
        $finish;
    end

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("CHECK FAILED at time %0t: %s (got %0h, expected %0h)",
                     $time, what, actual, expected);
        end
    endtask

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic rgbT expectedColor(input pixelT p);
        logic pOpq;
        logic bOpq;
        logic hOpq;
        int   green;
        rgbT  result;
        pOpq  = p.pHit && (p.pIdx != TransparentIndex);
        bOpq  = p.bHit && (p.bIdx != TransparentIndex);
        hOpq  = p.hHit && (p.hIdx != TransparentIndex);
        green = int'(BackgroundGreenBase) + (6 * int'(p.y)) / 25;
        if (p.pHit && pOpq)
            result = PaletteColors[p.pIdx];
        else if (p.pHit && p.hHit && hOpq)
            result = PaletteColors[p.hIdx];
        else if (p.pHit && !p.hHit && p.bHit && bOpq)
            result = PaletteColors[p.bIdx];
        else if (!p.pHit && p.bHit && bOpq)
            result = PaletteColors[p.bIdx];
        else if (!p.pHit && !p.bHit && p.hHit && hOpq)
            result = PaletteColors[p.hIdx];
        else if (p.bullet)
            result = BulletColor;
        else
            result = {BackgroundRed, 8'(green), BackgroundBlue};
        return result;
    endfunction

    // Uses the control inputs currently on the DUT pins
    task automatic updateStatus(input expectT e);
        coordT footY;
        coordT headY;
        coordT sideX;
        logic  hit;
        logic  rise;
        footY = playerY + GroundProbeOffset;
        headY = playerY - GroundProbeOffset;
        sideX = facingRight ? playerX + SideProbeOffset : playerX - SideProbeOffset;
        hit   = e.pOpq && e.hOpq;
        rise  = hit && !modelDead && !restart;
        if (restart)
            modelDead = 1'b0;
        else if (hit)
            modelDead = 1'b1;
        if (clearCount)
            modelLife = '0;
        else if (rise && modelLife < LifeCountMax)
            modelLife = modelLife + 7'd1;
        if (e.x == playerX && e.y == footY)
            modelInAir = !e.bOpq;
        if (e.x == playerX && e.y == headY)
            modelTop = e.bOpq;
        if (e.x == sideX && e.y == playerY)
            modelBlocked = e.bOpq;
    endtask

    // Status first, then the pixel three edges old
    always @(negedge Clk)
    begin
        if (arstN)
        begin
            checkValue(dead, modelDead, "dead flag");
            checkValue(inAir, modelInAir, "inAir flag");
            checkValue(blocked, modelBlocked, "blocked flag");
            checkValue(top, modelTop, "top flag");
            checkValue(lifeCount, modelLife, "life count");
            if (expectQ.size() > 3)
            begin
                popped = expectQ.pop_front();
                checkValue({vgaRed, vgaGreen, vgaBlue}, popped.color, "pixel colour");
                updateStatus(popped);
            end
        end
    end

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    task automatic step(input pixelT p);
        expectT e;
        @(posedge Clk);
        drawX       <= p.x;
        drawY       <= p.y;
        playerHit   <= p.pHit;
        playerIndex <= p.pIdx;
        blockHit    <= p.bHit;
        blockIndex  <= p.bIdx;
        hazardHit   <= p.hHit;
        hazardIndex <= p.hIdx;
        bulletHit   <= p.bullet;
        playerX     <= ctlPlayerX;
        playerY     <= ctlPlayerY;
        facingRight <= ctlFacing;
        restart     <= ctlRestart;
        clearCount  <= ctlClear;
        e.color = expectedColor(p);
        e.x     = p.x;
        e.y     = p.y;
        e.pOpq  = p.pHit && (p.pIdx != TransparentIndex);
        e.bOpq  = p.bHit && (p.bIdx != TransparentIndex);
        e.hOpq  = p.hHit && (p.hIdx != TransparentIndex);
        expectQ.push_back(e);
    endtask

    function automatic paletteIndexT randomIndex();
        paletteIndexT idx;
        if ($urandom % 4 == 0)
            idx = TransparentIndex;
        else
            // Entries 60 to 63 are unused copies of the key
            idx = paletteIndexT'(1 + $urandom % 59);
        return idx;
    endfunction

    function automatic pixelT randomPixel();
        pixelT p;
        p.x      = coordT'($urandom % 1024);
        p.y      = coordT'($urandom % 1024);
        p.pHit   = 1'($urandom % 2);
        p.pIdx   = randomIndex();
        p.bHit   = 1'($urandom % 2);
        p.bIdx   = randomIndex();
        p.hHit   = 1'($urandom % 2);
        p.hIdx   = randomIndex();
        p.bullet = 1'($urandom % 2);
        return p;
    endfunction

    // Far from every probe point used here
    function automatic pixelT idlePixel();
        pixelT p;
        p   = '0;
        p.x = 10'd700;
        p.y = 10'd500;
        return p;
    endfunction

    function automatic pixelT overlapPixel(input paletteIndexT pIdx, input paletteIndexT hIdx);
        pixelT p;
        p      = '0;
        p.x    = 10'd650;
        p.y    = 10'd450;
        p.pHit = 1'b1;
        p.pIdx = pIdx;
        p.hHit = 1'b1;
        p.hIdx = hIdx;
        return p;
    endfunction

    function automatic pixelT blockPixel(input coordT x, input coordT y, input logic opaque);
        pixelT p;
        p      = '0;
        p.x    = x;
        p.y    = y;
        p.bHit = 1'b1;
        p.bIdx = opaque ? 6'd21 : TransparentIndex;
        return p;
    endfunction

    // Long enough for a pixel to reach the status flags
    task automatic drainPipeline();
        repeat (5) step(idlePixel());
        @(negedge Clk);
    endtask

    task automatic reportTest(input string name, input int checksBefore, input int errorsBefore);
        $display("test %s: %0d checks, %0d errors", name,
                 checkCount - checksBefore, errorCount - errorsBefore);
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic testLayerPriority();
        int c0;
        int e0;
        c0 = checkCount;
        e0 = errorCount;
        repeat (400) step(randomPixel());
        drainPipeline();
        reportTest("layer priority", c0, e0);
    endtask

    task automatic testBackground();
        pixelT p;
        int    c0;
        int    e0;
        c0 = checkCount;
        e0 = errorCount;
        repeat (300)
        begin
            p      = randomPixel();
            p.pIdx = TransparentIndex;
            p.bIdx = TransparentIndex;
            p.hIdx = TransparentIndex;
            step(p);
        end
        drainPipeline();
        reportTest("background and bullet", c0, e0);
    endtask

    task automatic testDeath();
        int c0;
        int e0;
        c0 = checkCount;
        e0 = errorCount;
        ctlRestart = 1'b1;
        ctlClear   = 1'b1;
        step(idlePixel());
        ctlRestart = 1'b0;
        ctlClear   = 1'b0;
        drainPipeline();
        checkValue(dead, 1'b0, "dead after restart");
        checkValue(lifeCount, 7'd0, "life count after clear");
        step(overlapPixel(6'd0, 6'd7));
        drainPipeline();
        checkValue(dead, 1'b0, "dead after transparent player overlap");
        step(overlapPixel(6'd3, 6'd0));
        drainPipeline();
        checkValue(dead, 1'b0, "dead after transparent hazard overlap");
        step(overlapPixel(6'd3, 6'd7));
        drainPipeline();
        checkValue(dead, 1'b1, "dead after opaque overlap");
        checkValue(lifeCount, 7'd1, "life count after first death");
        repeat (10) step(idlePixel());
        @(negedge Clk);
        checkValue(dead, 1'b1, "dead holds without restart");
        // Restart held across overlapping pixels keeps dead low
        ctlRestart = 1'b1;
        repeat (6) step(overlapPixel(6'd3, 6'd7));
        repeat (4) step(idlePixel());
        @(negedge Clk);
        checkValue(dead, 1'b0, "restart wins over hit");
        ctlRestart = 1'b0;
        drainPipeline();
        checkValue(dead, 1'b0, "dead stays clear after restart");
        checkValue(lifeCount, 7'd1, "life count unchanged by restart");
        reportTest("death", c0, e0);
    endtask

    task automatic testLifeCounter();
        int c0;
        int e0;
        c0 = checkCount;
        e0 = errorCount;
        ctlClear = 1'b1;
        step(idlePixel());
        ctlClear = 1'b0;
        for (int r = 1; r <= 105; r++)
        begin
            step(overlapPixel(6'd3, 6'd7));
            drainPipeline();
            checkValue(dead, 1'b1, "dead in death round");
            checkValue(lifeCount, (r < 99) ? r : 99, "life count after death round");
            ctlRestart = 1'b1;
            step(idlePixel());
            ctlRestart = 1'b0;
        end
        ctlClear = 1'b1;
        step(idlePixel());
        ctlClear = 1'b0;
        drainPipeline();
        checkValue(lifeCount, 7'd0, "life count after clearCount");
        reportTest("life counter", c0, e0);
    endtask

    task automatic testProbes();
        coordT px;
        coordT py;
        coordT sideX;
        coordT otherX;
        logic  footOpq;
        logic  headOpq;
        logic  sideOpq;
        int    c0;
        int    e0;
        c0 = checkCount;
        e0 = errorCount;
        for (int r = 0; r < 8; r++)
        begin
            px         = coordT'(100 + $urandom % 400);
            py         = coordT'(100 + $urandom % 300);
            ctlPlayerX = px;
            ctlPlayerY = py;
            ctlFacing  = r[0];
            repeat (2) step(idlePixel());
            sideX   = ctlFacing ? px + SideProbeOffset : px - SideProbeOffset;
            otherX  = ctlFacing ? px - SideProbeOffset : px + SideProbeOffset;
            footOpq = 1'($urandom % 2);
            headOpq = 1'($urandom % 2);
            sideOpq = 1'($urandom % 2);
            step(blockPixel(px, py + GroundProbeOffset, footOpq));
            drainPipeline();
            checkValue(inAir, !footOpq, "inAir at foot probe");
            step(blockPixel(px, py - GroundProbeOffset, headOpq));
            drainPipeline();
            checkValue(top, headOpq, "top at head probe");
            step(blockPixel(sideX, py, sideOpq));
            drainPipeline();
            checkValue(blocked, sideOpq, "blocked at side probe");
            // Off-probe pixels with the opposite opacity
            step(blockPixel(otherX, py, !sideOpq));
            drainPipeline();
            checkValue(blocked, sideOpq, "blocked unchanged behind player");
            step(blockPixel(px + 10'd1, py + GroundProbeOffset, !footOpq));
            step(blockPixel(px + 10'd1, py - GroundProbeOffset, !headOpq));
            drainPipeline();
            checkValue(inAir, !footOpq, "inAir unchanged beside foot probe");
            checkValue(top, headOpq, "top unchanged beside head probe");
        end
        reportTest("probes", c0, e0);
    endtask

    initial
    begin
        void'($urandom(Seed));
        arstN        = 1'b0;
        drawX        = '0;
        drawY        = '0;
        playerHit    = 1'b0;
        playerIndex  = '0;
        blockHit     = 1'b0;
        blockIndex   = '0;
        hazardHit    = 1'b0;
        hazardIndex  = '0;
        bulletHit    = 1'b0;
        playerX      = '0;
        playerY      = '0;
        facingRight  = 1'b0;
        restart      = 1'b0;
        clearCount   = 1'b0;
        ctlPlayerX   = '0;
        ctlPlayerY   = '0;
        ctlFacing    = 1'b0;
        ctlRestart   = 1'b0;
        ctlClear     = 1'b0;
        modelDead    = 1'b0;
        modelInAir   = 1'b0;
        modelBlocked = 1'b0;
        modelTop     = 1'b0;
        modelLife    = '0;
        checkCount   = 0;
        errorCount   = 0;
        repeat (ResetCycles) @(posedge Clk);
        arstN <= 1'b1;

        testLayerPriority();
        testBackground();
        testDeath();
        testLifeCounter();
        testProbes();

        $display("tests run: 5, checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+design
design/colorPkg.sv
design/layerSelect.sv
design/paletteLookup.sv
design/pixelCompositor.sv
design/probeMonitor.sv
design/colorMapper.sv
verification/colorMapperTb.sv

//--- Bender.yml
package:
  name: color_mapper

sources:
  - include_dirs:
      - design
    files:
      - design/colorPkg.sv
      - design/layerSelect.sv
      - design/paletteLookup.sv
      - design/pixelCompositor.sv
      - design/probeMonitor.sv
      - design/colorMapper.sv

  - target: test
    files:
      - verification/colorMapperTb.sv
